//--- rtl/ffu_pkg.sv
`default_nettype none

package ffu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths and sizes
   ////////////////////////////////////////////////////////////////////////////

   localparam int FFU_DATA_W  = 64;                 // FRF entry and VIS operand
   localparam int FFU_NREG    = 32;                 // Double-precision FRF entries
   localparam int FFU_REG_W   = 5;                  // Register number
   localparam int FFU_OPC_W   = 9;                  // Raw fpopcode field
   localparam int FFU_ALIGN_W = 3;                  // GSR align, byte offset 0..7

   ////////////////////////////////////////////////////////////////////////////
   // Raw VIS operation codes
   ////////////////////////////////////////////////////////////////////////////

   localparam logic [FFU_OPC_W-1:0] OPC_FPADD16 = 9'h050;
   localparam logic [FFU_OPC_W-1:0] OPC_FPADD32 = 9'h052;
   localparam logic [FFU_OPC_W-1:0] OPC_FPSUB16 = 9'h054;
   localparam logic [FFU_OPC_W-1:0] OPC_FPSUB32 = 9'h056;
   localparam logic [FFU_OPC_W-1:0] OPC_FAND    = 9'h070;
   localparam logic [FFU_OPC_W-1:0] OPC_FOR     = 9'h07c;
   localparam logic [FFU_OPC_W-1:0] OPC_FXOR    = 9'h06c;
   localparam logic [FFU_OPC_W-1:0] OPC_FNAND   = 9'h06e;
   localparam logic [FFU_OPC_W-1:0] OPC_FALIGN  = 9'h048; // faligndata

   // Decoded operation carried into execute
   typedef enum logic [3:0] {
      VIS_ADD16,                                    // Four 16-bit lanes
      VIS_ADD32,                                    // Two 32-bit lanes
      VIS_SUB16,
      VIS_SUB32,
      VIS_AND,
      VIS_OR,
      VIS_XOR,
      VIS_NAND,
      VIS_ALIGN,                                    // Byte align on rs1:rs2
      VIS_STORE                                     // Read rs2 out to store data
   } vis_op_t;

endpackage

`default_nettype wire

//--- rtl/ffu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ffu_decode (
   input  logic                              rclk,
   input  logic                              rst_n,
   input  logic                              fpop_vld,   // VIS op strobe
   input  logic                              fst_vld,    // Store strobe
   input  logic [ffu_pkg::FFU_OPC_W-1:0]     fpopcode,
   input  logic [ffu_pkg::FFU_REG_W-1:0]     frs1,
   input  logic [ffu_pkg::FFU_REG_W-1:0]     frs2,
   input  logic [ffu_pkg::FFU_REG_W-1:0]     frd,
   input  logic                              gsr_wr,
   input  logic [ffu_pkg::FFU_ALIGN_W-1:0]   gsr_align,
   output logic                              e_vld,
   output ffu_pkg::vis_op_t                  e_op,
   output logic [ffu_pkg::FFU_REG_W-1:0]     e_rs1,
   output logic [ffu_pkg::FFU_REG_W-1:0]     e_rs2,
   output logic [ffu_pkg::FFU_REG_W-1:0]     e_rd,
   output logic [ffu_pkg::FFU_ALIGN_W-1:0]   e_align,
   output logic                              ill_inst
);

   import ffu_pkg::*;

   vis_op_t                  dec_op;                // Decoded fpopcode
   logic                     dec_known;             // Code found in table
   logic                     issue_op;
   logic                     issue_st;
   logic [FFU_ALIGN_W-1:0]   gsr_align_q;           // Graphics status align field

   ////////////////////////////////////////////////////////////////////////////
   // Opcode table
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      dec_op    = VIS_ADD16;
      dec_known = 1'b1;
      case (fpopcode)
         OPC_FPADD16: dec_op = VIS_ADD16;
         OPC_FPADD32: dec_op = VIS_ADD32;
         OPC_FPSUB16: dec_op = VIS_SUB16;
         OPC_FPSUB32: dec_op = VIS_SUB32;
         OPC_FAND:    dec_op = VIS_AND;
         OPC_FOR:     dec_op = VIS_OR;
         OPC_FXOR:    dec_op = VIS_XOR;
         OPC_FNAND:   dec_op = VIS_NAND;
         OPC_FALIGN:  dec_op = VIS_ALIGN;
         default:     dec_known = 1'b0;             // Unimplemented VIS op
      endcase
   end

   assign issue_op = fpop_vld & dec_known;
   assign issue_st = fst_vld & ~fpop_vld;           // fpop wins a collision

   ////////////////////////////////////////////////////////////////////////////
   // Execute stage control and GSR
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         e_vld       <= 1'b0;
         ill_inst    <= 1'b0;
         gsr_align_q <= '0;
      end else begin
         e_vld    <= issue_op | issue_st;
         ill_inst <= fpop_vld & ~dec_known;         // One-cycle pulse, no issue
         if (gsr_wr) begin
            gsr_align_q <= gsr_align;
         end
      end
   end

   // Instruction fields, only meaningful while e_vld is high
   always_ff @(posedge rclk) begin
      if (issue_op) begin
         e_op    <= dec_op;
         e_rs1   <= frs1;
         e_rs2   <= frs2;
         e_rd    <= frd;
         e_align <= gsr_align_q;                    // Old value on same-edge gsr_wr
      end else if (issue_st) begin
         e_op    <= VIS_STORE;
         e_rs2   <= frs2;                           // Store data source
      end
   end

endmodule

`default_nettype wire

//--- rtl/ffu_frf.sv
`timescale 1ns/1ps
`default_nettype none

module ffu_frf (
   input  logic                              rclk,
   input  logic                              rst_n,
   input  logic [ffu_pkg::FFU_REG_W-1:0]     e_rs1,
   input  logic [ffu_pkg::FFU_REG_W-1:0]     e_rs2,
   input  logic                              w_wen,      // Writeback port
   input  logic [ffu_pkg::FFU_REG_W-1:0]     w_rd,
   input  logic [ffu_pkg::FFU_DATA_W-1:0]    w_data,
   input  logic                              ld_vld,     // Load data port
   input  logic [ffu_pkg::FFU_REG_W-1:0]     ld_rd,
   input  logic [ffu_pkg::FFU_DATA_W-1:0]    ld_data,
   output logic [ffu_pkg::FFU_DATA_W-1:0]    rs1_data,
   output logic [ffu_pkg::FFU_DATA_W-1:0]    rs2_data
);

   import ffu_pkg::*;

   logic [FFU_DATA_W-1:0]    frf_mem [FFU_NREG];
   logic                     ld_wins;               // Load not shadowed by writeback

   // Writeback beats the load port on the same entry
   assign ld_wins = ld_vld & ~(w_wen & (w_rd == ld_rd));

   ////////////////////////////////////////////////////////////////////////////
   // Array write
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < FFU_NREG; i++) begin
            frf_mem[i] <= '0;
         end
      end else begin
         if (w_wen) begin
            frf_mem[w_rd] <= w_data;
         end
         if (ld_wins) begin
            frf_mem[ld_rd] <= ld_data;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read with write-through bypass
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [FFU_DATA_W-1:0] frf_read(input logic [FFU_REG_W-1:0] addr);
      logic [FFU_DATA_W-1:0] rdata;
      rdata = frf_mem[addr];
      if (w_wen && (w_rd == addr)) begin
         rdata = w_data;                            // Result in writeback
      end else if (ld_vld && (ld_rd == addr)) begin
         rdata = ld_data;                           // Load landing this cycle
      end
      return rdata;
   endfunction

   always_comb begin
      rs1_data = frf_read(e_rs1);
      rs2_data = frf_read(e_rs2);
   end

endmodule

`default_nettype wire

//--- rtl/ffu_vis.sv
`timescale 1ns/1ps
`default_nettype none

module ffu_vis (
   input  logic                              rclk,
   input  logic                              rst_n,
   input  logic                              e_vld,
   input  ffu_pkg::vis_op_t                  e_op,
   input  logic [ffu_pkg::FFU_REG_W-1:0]     e_rd,
   input  logic [ffu_pkg::FFU_ALIGN_W-1:0]   e_align,
   input  logic [ffu_pkg::FFU_DATA_W-1:0]    rs1_data,
   input  logic [ffu_pkg::FFU_DATA_W-1:0]    rs2_data,
   output logic                              w_wen,
   output logic [ffu_pkg::FFU_REG_W-1:0]     w_rd,
   output logic [ffu_pkg::FFU_DATA_W-1:0]    w_data,
   output logic                              done,       // VIS op complete
   output logic [ffu_pkg::FFU_DATA_W-1:0]    result,
   output logic [ffu_pkg::FFU_REG_W-1:0]     result_rd,
   output logic                              st_vld,
   output logic [ffu_pkg::FFU_DATA_W-1:0]    st_data
);

   import ffu_pkg::*;

   logic                     is_sub;
   logic                     is_store;
   logic [FFU_DATA_W-1:0]    add16_res;             // Four 16-bit lanes
   logic [FFU_DATA_W-1:0]    add32_res;             // Two 32-bit lanes
   logic [FFU_DATA_W-1:0]    log_res;
   logic [2*FFU_DATA_W-1:0]  align_cat;             // rs1 above rs2
   logic [2*FFU_DATA_W-1:0]  align_shift;
   logic [FFU_DATA_W-1:0]    align_res;
   logic [FFU_DATA_W-1:0]    vis_res;

   assign is_sub   = (e_op == VIS_SUB16) || (e_op == VIS_SUB32);
   assign is_store = (e_op == VIS_STORE);

   ////////////////////////////////////////////////////////////////////////////
   // Partitioned adder
   ////////////////////////////////////////////////////////////////////////////

   // No carry crosses a lane boundary; each lane wraps on its own
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         if (is_sub) begin
            add16_res[16*i +: 16] = rs1_data[16*i +: 16] - rs2_data[16*i +: 16];
         end else begin
            add16_res[16*i +: 16] = rs1_data[16*i +: 16] + rs2_data[16*i +: 16];
         end
      end
      for (int j = 0; j < 2; j++) begin
         if (is_sub) begin
            add32_res[32*j +: 32] = rs1_data[32*j +: 32] - rs2_data[32*j +: 32];
         end else begin
            add32_res[32*j +: 32] = rs1_data[32*j +: 32] + rs2_data[32*j +: 32];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Logical unit and aligner
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (e_op)
         VIS_AND:  log_res = rs1_data & rs2_data;
         VIS_OR:   log_res = rs1_data | rs2_data;
         VIS_XOR:  log_res = rs1_data ^ rs2_data;
         default:  log_res = ~(rs1_data & rs2_data); // fnand
      endcase
   end

   // Drop align bytes off the top, keep the next eight
   assign align_cat   = {rs1_data, rs2_data};
   assign align_shift = align_cat << {e_align, 3'b000};
   assign align_res   = align_shift[2*FFU_DATA_W-1 -: FFU_DATA_W];

   // Result select
   always_comb begin
      case (e_op)
         VIS_ADD16, VIS_SUB16:             vis_res = add16_res;
         VIS_ADD32, VIS_SUB32:             vis_res = add32_res;
         VIS_AND, VIS_OR, VIS_XOR, VIS_NAND: vis_res = log_res;
         VIS_ALIGN:                        vis_res = align_res;
         default:                          vis_res = rs2_data; // Store passes rs2
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Writeback stage
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         w_wen  <= 1'b0;
         st_vld <= 1'b0;
      end else begin
         w_wen  <= e_vld & ~is_store;
         st_vld <= e_vld & is_store;
      end
   end

   always_ff @(posedge rclk) begin
      if (e_vld && !is_store) begin
         w_rd   <= e_rd;
         w_data <= vis_res;
      end
      if (e_vld && is_store) begin
         st_data <= vis_res;
      end
   end

   // Completion reported in the same cycle the write is presented
   assign done      = w_wen;
   assign result    = w_data;
   assign result_rd = w_rd;

endmodule

`default_nettype wire

//--- rtl/ffu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ffu_top (
   input  logic                              rclk,
   input  logic                              rst_n,
   input  logic                              fpop_vld,
   input  logic                              fst_vld,
   input  logic [ffu_pkg::FFU_OPC_W-1:0]     fpopcode,
   input  logic [ffu_pkg::FFU_REG_W-1:0]     frs1,
   input  logic [ffu_pkg::FFU_REG_W-1:0]     frs2,
   input  logic [ffu_pkg::FFU_REG_W-1:0]     frd,
   input  logic                              gsr_wr,
   input  logic [ffu_pkg::FFU_ALIGN_W-1:0]   gsr_align,
   input  logic                              ld_vld,
   input  logic [ffu_pkg::FFU_REG_W-1:0]     ld_rd,
   input  logic [ffu_pkg::FFU_DATA_W-1:0]    ld_data,
   output logic                              done,
   output logic [ffu_pkg::FFU_DATA_W-1:0]    result,
   output logic [ffu_pkg::FFU_REG_W-1:0]     result_rd,
   output logic                              st_vld,
   output logic [ffu_pkg::FFU_DATA_W-1:0]    st_data,
   output logic                              ill_inst
);

   import ffu_pkg::*;

   // Execute stage
   logic                     e_vld;
   vis_op_t                  e_op;
   logic [FFU_REG_W-1:0]     e_rs1;
   logic [FFU_REG_W-1:0]     e_rs2;
   logic [FFU_REG_W-1:0]     e_rd;
   logic [FFU_ALIGN_W-1:0]   e_align;
   logic [FFU_DATA_W-1:0]    rs1_data;
   logic [FFU_DATA_W-1:0]    rs2_data;

   // Writeback stage
   logic                     w_wen;
   logic [FFU_REG_W-1:0]     w_rd;
   logic [FFU_DATA_W-1:0]    w_data;

   ffu_decode u_decode (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .fpop_vld  (fpop_vld),
      .fst_vld   (fst_vld),
      .fpopcode  (fpopcode),
      .frs1      (frs1),
      .frs2      (frs2),
      .frd       (frd),
      .gsr_wr    (gsr_wr),
      .gsr_align (gsr_align),
      .e_vld     (e_vld),
      .e_op      (e_op),
      .e_rs1     (e_rs1),
      .e_rs2     (e_rs2),
      .e_rd      (e_rd),
      .e_align   (e_align),
      .ill_inst  (ill_inst)
   );

   ffu_frf u_frf (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .e_rs1     (e_rs1),
      .e_rs2     (e_rs2),
      .w_wen     (w_wen),
      .w_rd      (w_rd),
      .w_data    (w_data),
      .ld_vld    (ld_vld),
      .ld_rd     (ld_rd),
      .ld_data   (ld_data),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data)
   );

   ffu_vis u_vis (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .e_vld     (e_vld),
      .e_op      (e_op),
      .e_rd      (e_rd),
      .e_align   (e_align),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data),
      .w_wen     (w_wen),
      .w_rd      (w_rd),
      .w_data    (w_data),
      .done      (done),
      .result    (result),
      .result_rd (result_rd),
      .st_vld    (st_vld),
      .st_data   (st_data)
   );

endmodule

`default_nettype wire

//--- tb/tb_ffu_tasks.svh
`ifndef TB_FFU_TASKS_SVH
`define TB_FFU_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Drive and wait helpers
////////////////////////////////////////////////////////////////////////////

task automatic drive_idle();
   fpop_vld <= 1'b0;
   fst_vld  <= 1'b0;
   gsr_wr   <= 1'b0;
   ld_vld   <= 1'b0;
endtask

task automatic drive_op(input logic [FFU_OPC_W-1:0] opc, input logic [FFU_REG_W-1:0] rs1,
                        input logic [FFU_REG_W-1:0] rs2, input logic [FFU_REG_W-1:0] rd);
   fpop_vld <= 1'b1;
   fpopcode <= opc;
   frs1     <= rs1;
   frs2     <= rs2;
   frd      <= rd;
endtask

task automatic drive_store(input logic [FFU_REG_W-1:0] rs);
   fst_vld <= 1'b1;
   frs2    <= rs;
endtask

task automatic drive_load(input logic [FFU_REG_W-1:0] rd, input logic [FFU_DATA_W-1:0] data);
   ld_vld  <= 1'b1;
   ld_rd   <= rd;
   ld_data <= data;
endtask

// Latency counts falling edges after the call
task automatic wait_done(input int exp_lat, input logic [FFU_REG_W-1:0] exp_rd,
                         input logic [FFU_DATA_W-1:0] exp_data);
   int cnt;
   cnt = 0;
   while (cnt == 0 || !done) begin
      @(negedge rclk);
      cnt++;
      if (cnt > WAIT_MAX) begin
         report_timeout("done");
      end
   end
   check_data("done latency", 64'(cnt), 64'(exp_lat));
   check_data("result_rd", 64'(result_rd), 64'(exp_rd));
   check_data("result", result, exp_data);
endtask

task automatic wait_store(input int exp_lat, input logic [FFU_DATA_W-1:0] exp_data);
   int cnt;
   cnt = 0;
   while (cnt == 0 || !st_vld) begin
      @(negedge rclk);
      cnt++;
      if (cnt > WAIT_MAX) begin
         report_timeout("st_vld");
      end
   end
   check_data("st_vld latency", 64'(cnt), 64'(exp_lat));
   check_data("st_data", st_data, exp_data);
   check_data("done on store", 64'(done), 64'd0);
endtask

task automatic load_reg(input logic [FFU_REG_W-1:0] rd, input logic [FFU_DATA_W-1:0] data);
   @(posedge rclk);
   drive_load(rd, data);
   @(posedge rclk);
   drive_idle();
   model_frf[rd] = data;
endtask

task automatic run_store(input logic [FFU_REG_W-1:0] rs);
   @(posedge rclk);
   drive_store(rs);
   @(posedge rclk);
   drive_idle();
   wait_store(2, model_frf[rs]);
endtask

task automatic run_op(input logic [FFU_OPC_W-1:0] opc, input logic [FFU_REG_W-1:0] rs1,
                      input logic [FFU_REG_W-1:0] rs2, input logic [FFU_REG_W-1:0] rd);
   logic [FFU_DATA_W-1:0] exp;
   exp = model_vis(opc, model_frf[rs1], model_frf[rs2], model_align);
   @(posedge rclk);
   drive_op(opc, rs1, rs2, rd);
   @(posedge rclk);
   drive_idle();
   wait_done(2, rd, exp);
   model_frf[rd] = exp;
   @(negedge rclk);
   check_data("done one cycle later", 64'(done), 64'd0);
endtask

task automatic set_align(input logic [FFU_ALIGN_W-1:0] align);
   @(posedge rclk);
   gsr_wr    <= 1'b1;
   gsr_align <= align;
   @(posedge rclk);
   drive_idle();
   model_align = align;
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_load_store();
   run_store(5'd31);                                // Still zero from reset
   for (int i = 0; i < 8; i++) begin
      load_reg(5'(3*i + 2), rand64());
   end
   for (int i = 0; i < 8; i++) begin
      run_store(5'(3*i + 2));
   end
endtask

task automatic lane_round(input logic [FFU_OPC_W-1:0] opc);
   load_reg(5'd1, rand64());
   load_reg(5'd2, rand64());
   run_op(opc, 5'd1, 5'd2, 5'd3);
   // Every lane carries or borrows out of its top bit
   load_reg(5'd1, 64'hffff_8000_7fff_ffff);
   load_reg(5'd2, 64'h0001_8000_8001_0001);
   run_op(opc, 5'd1, 5'd2, 5'd3);
   run_op(opc, 5'd2, 5'd1, 5'd4);
endtask

task automatic test_arith();
   lane_round(OPC_FPADD16);
   lane_round(OPC_FPADD32);
   lane_round(OPC_FPSUB16);
   lane_round(OPC_FPSUB32);
endtask

task automatic test_logic();
   load_reg(5'd4, rand64());
   load_reg(5'd5, rand64());
   run_op(OPC_FAND, 5'd4, 5'd5, 5'd6);
   run_op(OPC_FOR, 5'd4, 5'd5, 5'd7);
   run_op(OPC_FXOR, 5'd4, 5'd5, 5'd8);
   run_op(OPC_FNAND, 5'd4, 5'd5, 5'd9);
endtask

task automatic test_align();
   logic [FFU_DATA_W-1:0] exp;
   load_reg(5'd6, rand64());
   load_reg(5'd7, rand64());
   for (int a = 0; a < 8; a++) begin
      set_align(3'(a));
      run_op(OPC_FALIGN, 5'd6, 5'd7, 5'd8);
   end
   // GSR written on the op's own edge, op keeps the old offset
   exp = model_vis(OPC_FALIGN, model_frf[6], model_frf[7], model_align);
   @(posedge rclk);
   drive_op(OPC_FALIGN, 5'd6, 5'd7, 5'd9);
   gsr_wr    <= 1'b1;
   gsr_align <= 3'd2;
   @(posedge rclk);
   drive_idle();
   model_align = 3'd2;
   wait_done(2, 5'd9, exp);
   model_frf[9] = exp;
endtask

task automatic test_bypass();
   logic [FFU_DATA_W-1:0] ea;
   logic [FFU_DATA_W-1:0] eb;
   logic [FFU_DATA_W-1:0] ec;
   logic [FFU_DATA_W-1:0] ld_val;
   load_reg(5'd10, rand64());
   load_reg(5'd11, rand64());
   ea = model_vis(OPC_FPADD16, model_frf[10], model_frf[11], model_align);
   eb = model_vis(OPC_FXOR, ea, model_frf[10], model_align);
   ec = model_vis(OPC_FPSUB32, eb, ea, model_align);
   @(posedge rclk);
   drive_op(OPC_FPADD16, 5'd10, 5'd11, 5'd12);
   @(posedge rclk);
   drive_op(OPC_FXOR, 5'd12, 5'd10, 5'd13);         // r12 still in writeback
   @(posedge rclk);
   drive_op(OPC_FPSUB32, 5'd13, 5'd12, 5'd12);
   wait_done(1, 5'd12, ea);
   @(posedge rclk);
   drive_idle();
   wait_done(1, 5'd13, eb);
   wait_done(1, 5'd12, ec);
   model_frf[12] = ec;
   model_frf[13] = eb;
   // Load and store of one register on the same edge
   ld_val = rand64();
   @(posedge rclk);
   drive_load(5'd14, ld_val);
   drive_store(5'd14);
   @(posedge rclk);
   drive_idle();
   model_frf[14] = ld_val;
   wait_store(2, ld_val);
   // Load presented while the store of r15 sits in execute
   ld_val = rand64();
   @(posedge rclk);
   drive_store(5'd15);
   @(posedge rclk);
   fst_vld <= 1'b0;
   drive_load(5'd15, ld_val);
   @(posedge rclk);
   drive_idle();
   model_frf[15] = ld_val;
   wait_store(1, ld_val);
endtask

task automatic test_illegal();
   int cnt;
   load_reg(5'd20, rand64());
   @(posedge rclk);
   drive_op(9'h1ff, 5'd1, 5'd2, 5'd20);
   @(posedge rclk);
   drive_idle();
   cnt = 0;
   while (cnt == 0 || !ill_inst) begin
      @(negedge rclk);
      cnt++;
      check_data("done on illegal code", 64'(done), 64'd0);
      if (cnt > WAIT_MAX) begin
         report_timeout("ill_inst");
      end
   end
   check_data("ill_inst latency", 64'(cnt), 64'd1);
   repeat (2) begin
      @(negedge rclk);
      check_data("ill_inst after pulse", 64'(ill_inst), 64'd0);
      check_data("done after illegal code", 64'(done), 64'd0);
   end
   run_store(5'd20);                                // Target left untouched
endtask

`endif

//--- tb/tb_ffu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ffu;

   import ffu_pkg::*;

   localparam int CLK_HALF = 5;
   localparam int WAIT_MAX = 10;                    // Cycles before a wait gives up

   logic                     rclk;
   logic                     rst_n;
   logic                     fpop_vld;
   logic                     fst_vld;
   logic [FFU_OPC_W-1:0]     fpopcode;
   logic [FFU_REG_W-1:0]     frs1;
   logic [FFU_REG_W-1:0]     frs2;
   logic [FFU_REG_W-1:0]     frd;
   logic                     gsr_wr;
   logic [FFU_ALIGN_W-1:0]   gsr_align;
   logic                     ld_vld;
   logic [FFU_REG_W-1:0]     ld_rd;
   logic [FFU_DATA_W-1:0]    ld_data;
   logic                     done;
   logic [FFU_DATA_W-1:0]    result;
   logic [FFU_REG_W-1:0]     result_rd;
   logic                     st_vld;
   logic [FFU_DATA_W-1:0]    st_data;
   logic                     ill_inst;

   logic [FFU_DATA_W-1:0]    model_frf [FFU_NREG];  // Expected register file
   logic [FFU_ALIGN_W-1:0]   model_align;           // Expected GSR align field
   logic [31:0]              rng_state;

   ffu_top u_ffu_top (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .fpop_vld  (fpop_vld),
      .fst_vld   (fst_vld),
      .fpopcode  (fpopcode),
      .frs1      (frs1),
      .frs2      (frs2),
      .frd       (frd),
      .gsr_wr    (gsr_wr),
      .gsr_align (gsr_align),
      .ld_vld    (ld_vld),
      .ld_rd     (ld_rd),
      .ld_data   (ld_data),
      .done      (done),
      .result    (result),
      .result_rd (result_rd),
      .st_vld    (st_vld),
      .st_data   (st_data),
      .ill_inst  (ill_inst)
   );

   always #CLK_HALF rclk = ~rclk;

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic [FFU_DATA_W-1:0] rand64();
      return {next_random(), next_random()};
   endfunction

   function automatic logic [FFU_DATA_W-1:0] model_vis(input logic [FFU_OPC_W-1:0] opc,
         input logic [FFU_DATA_W-1:0] a, input logic [FFU_DATA_W-1:0] b,
         input logic [FFU_ALIGN_W-1:0] align);
      logic [FFU_DATA_W-1:0]   res;
      logic [2*FFU_DATA_W-1:0] cat;
      res = '0;
      cat = {a, b};
      case (opc)
         OPC_FPADD16: for (int i = 0; i < 4; i++) res[16*i +: 16] = a[16*i +: 16] + b[16*i +: 16];
         OPC_FPSUB16: for (int i = 0; i < 4; i++) res[16*i +: 16] = a[16*i +: 16] - b[16*i +: 16];
         OPC_FPADD32: for (int i = 0; i < 2; i++) res[32*i +: 32] = a[32*i +: 32] + b[32*i +: 32];
         OPC_FPSUB32: for (int i = 0; i < 2; i++) res[32*i +: 32] = a[32*i +: 32] - b[32*i +: 32];
         OPC_FAND:    res = a & b;
         OPC_FOR:     res = a | b;
         OPC_FXOR:    res = a ^ b;
         OPC_FNAND:   res = ~(a & b);
         // Byte i from the top comes from byte align+i of the 16-byte pair
         OPC_FALIGN: begin
            for (int i = 0; i < 8; i++) begin
               res[63 - 8*i -: 8] = cat[127 - 8*(i + int'(align)) -: 8];
            end
         end
         default:     res = '0;
      endcase
      return res;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Error reporting
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_error(input string msg);
      $display("ERROR @ %0t ns: %s", $time, msg);
      $display("Finished with errors");
      $fatal(1, "Stopped at first mismatch");
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out waiting for %s at %0t ns", what, $time);
      $display("Finished with errors");
      $fatal(1, "DUT did not respond");
   endtask

   task automatic check_data(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
      assert (got === exp) else begin
         report_error($sformatf("%s is %h, expected %h", what, got, exp));
      end
   endtask

   `include "tb_ffu_tasks.svh"

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      rclk        = 1'b0;
      rst_n       = 1'b0;
      fpop_vld    = 1'b0;
      fst_vld     = 1'b0;
      fpopcode    = '0;
      frs1        = '0;
      frs2        = '0;
      frd         = '0;
      gsr_wr      = 1'b0;
      gsr_align   = '0;
      ld_vld      = 1'b0;
      ld_rd       = '0;
      ld_data     = '0;
      rng_state   = 32'hbbabfc49;
      model_align = '0;
      for (int i = 0; i < FFU_NREG; i++) begin
         model_frf[i] = '0;
      end
      repeat (3) @(posedge rclk);
      rst_n <= 1'b1;
      @(negedge rclk);
      check_data("done after reset", 64'(done), 64'd0);
      check_data("st_vld after reset", 64'(st_vld), 64'd0);
      check_data("ill_inst after reset", 64'(ill_inst), 64'd0);
      test_load_store();
      test_arith();
      test_logic();
      test_align();
      test_bypass();
      test_illegal();
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+tb
rtl/ffu_pkg.sv
rtl/ffu_decode.sv
rtl/ffu_frf.sv
rtl/ffu_vis.sv
rtl/ffu_top.sv
tb/tb_ffu.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_ffu -f all.f -o tb_ffu &&
./obj_dir/tb_ffu || exit 1
